// ==== logic/armPkg.sv ====
// Shared widths, ALU and immediate codes, instruction classes, FSM states and constants
package armPkg;

	// Data, address and instruction word
	typedef logic [31:0] wordT;

	// Register number
	typedef logic [3:0] regAddrT;

	// Flags in the order N, Z, C, V
	typedef logic [3:0] flagsT;

	// Condition field of an instruction
	typedef logic [3:0] condT;

	// ALU operation
	typedef logic [2:0] aluCtrlT;

	localparam aluCtrlT aluAdd = 3'd0;
	localparam aluCtrlT aluSub = 3'd1;
	localparam aluCtrlT aluAnd = 3'd2;
	localparam aluCtrlT aluOrr = 3'd3;
	localparam aluCtrlT aluEor = 3'd4;
	localparam aluCtrlT aluMul = 3'd5;

	// Immediate formats
	typedef logic [1:0] immSrcT;

	localparam immSrcT immDp     = 2'd0;
	localparam immSrcT immMem    = 2'd1;
	localparam immSrcT immBranch = 2'd2;

	// Instruction classes, bits 27:26
	localparam logic [1:0] opDp     = 2'd0;
	localparam logic [1:0] opMem    = 2'd1;
	localparam logic [1:0] opBranch = 2'd2;

	// Bits 7:4 of a MUL
	localparam logic [3:0] mulMarker = 4'd9;

	localparam regAddrT pcReg  = 4'd15;
	localparam wordT    pcStep = 32'd4;

	// Memory depth in words
	localparam int memWords = 64;

	typedef enum logic [3:0] {
		fetch,
		decode,
		memAdr,
		memRead,
		memWb,
		memWrite,
		executeR,
		executeI,
		aluWb,
		branch,
		unknown
	} fsmStateT;

endpackage

// ==== logic/alu.sv ====
// ALU: add, subtract, AND, ORR, EOR and low-word multiply with NZCV flags
`timescale 1ns/1ns

module alu (
	input  armPkg::wordT    a,
	input  armPkg::wordT    b,
	input  armPkg::aluCtrlT aluControl,
	output armPkg::wordT    result,
	output armPkg::flagsT   flags
);
	import armPkg::*;

	logic        isSub;
	logic        isArith;
	wordT        condInvB;
	logic [32:0] sum;
	wordT        product;

	assign isSub   = (aluControl == aluSub);
	assign isArith = (aluControl == aluAdd) | isSub;

	// One adder for both, subtract as a + ~b + 1
	assign condInvB = isSub ? ~b : b;
	assign sum      = {1'b0, a} + {1'b0, condInvB} + {32'd0, isSub};

	// Low 32 bits of the product only
	assign product = a * b;

	always_comb begin
		case (aluControl)
			aluAnd:  result = a & b;
			aluOrr:  result = a | b;
			aluEor:  result = a ^ b;
			aluMul:  result = product;
			default: result = sum[31:0];
		endcase
	end

	assign flags[3] = result[31];
	assign flags[2] = (result == '0);
	assign flags[1] = isArith & sum[32];
	// Overflow when the operands agree in sign and the sum does not
	assign flags[0] = isArith & ~(a[31] ^ b[31] ^ isSub) & (a[31] ^ sum[31]);

endmodule

// ==== logic/regFile.sv ====
// Register file: fifteen registers, two read ports, one write port and the R15 bypass
`timescale 1ns/1ns

module regFile (
	input  logic            clk,
	input  logic            we,
	input  armPkg::regAddrT ra1,
	input  armPkg::regAddrT ra2,
	input  armPkg::regAddrT wa,
	input  armPkg::wordT    wd,
	input  armPkg::wordT    r15,
	output armPkg::wordT    rd1,
	output armPkg::wordT    rd2
);
	import armPkg::*;

	wordT regs [15];

	// R15 lives in the PC, never in the array
	always_ff @(posedge clk) begin
		if (we && (wa != pcReg)) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == pcReg) ? r15 : regs[ra1];
	assign rd2 = (ra2 == pcReg) ? r15 : regs[ra2];

endmodule

// ==== logic/datapath.sv ====
// Datapath: PC, instruction and data registers, operand selects, immediate extension, result select
`timescale 1ns/1ns

module datapath (
	input  logic            clk,
	input  logic            reset,
	input  armPkg::wordT    readData,
	input  logic            irWrite,
	input  logic            adrSrc,
	input  logic            aluSrcA,
	input  logic [1:0]      aluSrcB,
	input  logic [1:0]      resultSrc,
	input  armPkg::immSrcT  immSrc,
	input  logic [1:0]      regSrc,
	input  logic            regSrcMul,
	input  armPkg::aluCtrlT aluControl,
	input  logic            pcWrite,
	input  logic            regWrite,
	output armPkg::wordT    adr,
	output armPkg::wordT    writeData,
	output armPkg::wordT    instr,
	output armPkg::flagsT   aluFlags
);
	import armPkg::*;

	wordT    pc;
	wordT    data;
	wordT    srcRegA;
	wordT    rd1;
	wordT    rd2;
	wordT    extImm;
	wordT    srcA;
	wordT    srcB;
	wordT    aluResult;
	wordT    aluOut;
	wordT    result;
	regAddrT ra1;
	regAddrT ra2;
	regAddrT wa;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc    <= '0;
			instr <= '0;
		end else begin
			if (pcWrite) begin
				pc <= result;
			end
			if (irWrite) begin
				instr <= readData;
			end
		end
	end

	// Data, operand and ALU result registers load every cycle
	always_ff @(posedge clk) begin
		data      <= readData;
		srcRegA   <= rd1;
		writeData <= rd2;
		aluOut    <= aluResult;
	end

	assign adr = adrSrc ? result : pc;

	// MUL takes Rd from 19:16 and sources from 3:0 and 11:8
	assign ra1 = regSrc[0] ? pcReg : (regSrcMul ? instr[3:0] : instr[19:16]);
	assign ra2 = regSrc[1] ? instr[15:12] : (regSrcMul ? instr[11:8] : instr[3:0]);
	assign wa  = regSrcMul ? instr[19:16] : instr[15:12];

	regFile u_regFile (
		.clk (clk),
		.we  (regWrite),
		.ra1 (ra1),
		.ra2 (ra2),
		.wa  (wa),
		.wd  (result),
		.r15 (result),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	always_comb begin
		case (immSrc)
			immDp:     extImm = {24'd0, instr[7:0]};
			immMem:    extImm = {20'd0, instr[11:0]};
			immBranch: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
			default:   extImm = '0;
		endcase
	end

	assign srcA = aluSrcA ? pc : srcRegA;

	always_comb begin
		case (aluSrcB)
			2'b00:   srcB = writeData;
			2'b01:   srcB = extImm;
			default: srcB = pcStep;
		endcase
	end

	alu u_alu (
		.a          (srcA),
		.b          (srcB),
		.aluControl (aluControl),
		.result     (aluResult),
		.flags      (aluFlags)
	);

	always_comb begin
		case (resultSrc)
			2'b00:   result = aluOut;
			2'b01:   result = data;
			default: result = aluResult;
		endcase
	end

endmodule

// ==== logic/condUnit.sv ====
// Flag registers, condition check and gating of register, memory and PC writes
`timescale 1ns/1ns

module condUnit (
	input  logic          clk,
	input  logic          reset,
	input  armPkg::condT  cond,
	input  armPkg::flagsT aluFlags,
	input  logic [1:0]    flagW,
	input  logic          pcs,
	input  logic          nextPc,
	input  logic          regW,
	input  logic          memW,
	output logic          pcWrite,
	output logic          regWrite,
	output logic          memWrite
);
	import armPkg::*;

	flagsT      flags;
	logic [1:0] flagWrite;
	logic       condEx;
	logic       condExReg;
	logic       neg;
	logic       zero;
	logic       carry;
	logic       overflow;
	logic       ge;

	assign flagWrite = flagW & {2{condEx}};

	// N,Z and C,V pairs load separately
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags     <= '0;
			condExReg <= 1'b0;
		end else begin
			if (flagWrite[1]) begin
				flags[3:2] <= aluFlags[3:2];
			end
			if (flagWrite[0]) begin
				flags[1:0] <= aluFlags[1:0];
			end
			condExReg <= condEx;
		end
	end

	assign {neg, zero, carry, overflow} = flags;
	assign ge = (neg == overflow);

	always_comb begin
		case (cond)
			4'd0:    condEx = zero;
			4'd1:    condEx = ~zero;
			4'd2:    condEx = carry;
			4'd3:    condEx = ~carry;
			4'd4:    condEx = neg;
			4'd5:    condEx = ~neg;
			4'd6:    condEx = overflow;
			4'd7:    condEx = ~overflow;
			4'd8:    condEx = carry & ~zero;
			4'd9:    condEx = ~(carry & ~zero);
			4'd10:   condEx = ge;
			4'd11:   condEx = ~ge;
			4'd12:   condEx = ~zero & ge;
			4'd13:   condEx = ~(~zero & ge);
			4'd14:   condEx = 1'b1;
			// Code 15 never executes
			default: condEx = 1'b0;
		endcase
	end

	// Writes one cycle after the check use the registered result
	assign regWrite = regW & condExReg;
	assign memWrite = memW & condExReg;
	assign pcWrite  = (pcs & condExReg) | nextPc;

endmodule

// ==== logic/controlFsm.sv ====
// Multicycle control FSM with ALU decoder, immediate and register-source decode, PC-write request
`timescale 1ns/1ns

module controlFsm (
	input  logic            clk,
	input  logic            reset,
	input  armPkg::wordT    instr,
	output logic            irWrite,
	output logic            adrSrc,
	output logic            aluSrcA,
	output logic            regW,
	output logic            memW,
	output logic            nextPc,
	output logic            pcs,
	output logic            regSrcMul,
	output logic [1:0]      aluSrcB,
	output logic [1:0]      resultSrc,
	output armPkg::immSrcT  immSrc,
	output logic [1:0]      regSrc,
	output armPkg::aluCtrlT aluControl,
	output logic [1:0]      flagW
);
	import armPkg::*;

	fsmStateT   state;
	fsmStateT   nextState;
	logic [1:0] op;
	logic [3:0] cmd;
	logic       sBit;
	logic       aluOp;
	logic       isBranch;
	regAddrT    dest;

	assign op   = instr[27:26];
	assign cmd  = instr[24:21];
	assign sBit = instr[20];

	// MUL sits in the register form of cmd 0 with 1001 in bits 7:4
	assign regSrcMul = (op == opDp) & ~instr[25] & (cmd == 4'b0000)
		& (instr[7:4] == mulMarker);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			fetch:  nextState = decode;
			decode: begin
				case (op)
					opDp:     nextState = instr[25] ? executeI : executeR;
					opMem:    nextState = memAdr;
					opBranch: nextState = branch;
					default:  nextState = unknown;
				endcase
			end
			// L bit picks load or store
			memAdr:   nextState = instr[20] ? memRead : memWrite;
			memRead:  nextState = memWb;
			executeR: nextState = aluWb;
			executeI: nextState = aluWb;
			default:  nextState = fetch;
		endcase
	end

	// Selects: aluSrcB 0 reg, 1 imm, 2 step; resultSrc 0 aluOut, 1 data, 2 aluResult
	always_comb begin
		irWrite   = 1'b0;
		adrSrc    = 1'b0;
		aluSrcA   = 1'b0;
		aluSrcB   = 2'b00;
		resultSrc = 2'b00;
		nextPc    = 1'b0;
		regW      = 1'b0;
		memW      = 1'b0;
		isBranch  = 1'b0;
		aluOp     = 1'b0;
		case (state)
			fetch: begin
				irWrite   = 1'b1;
				aluSrcA   = 1'b1;
				aluSrcB   = 2'b10;
				resultSrc = 2'b10;
				nextPc    = 1'b1;
			end
			// PC + 4 again, seen as R15 by the register reads
			decode: begin
				aluSrcA   = 1'b1;
				aluSrcB   = 2'b10;
				resultSrc = 2'b10;
			end
			memAdr:  aluSrcB = 2'b01;
			memRead: adrSrc = 1'b1;
			memWb: begin
				resultSrc = 2'b01;
				regW      = 1'b1;
			end
			memWrite: begin
				adrSrc = 1'b1;
				memW   = 1'b1;
			end
			executeR: aluOp = 1'b1;
			executeI: begin
				aluSrcB = 2'b01;
				aluOp   = 1'b1;
			end
			aluWb: regW = 1'b1;
			branch: begin
				aluSrcB   = 2'b01;
				resultSrc = 2'b10;
				isBranch  = 1'b1;
			end
			default: ;
		endcase
	end

	// ALU decoder, address arithmetic defaults to add
	always_comb begin
		aluControl = aluAdd;
		flagW      = 2'b00;
		if (aluOp) begin
			if (regSrcMul) begin
				aluControl = aluMul;
			end else begin
				case (cmd)
					4'b0100: aluControl = aluAdd;
					4'b0010: aluControl = aluSub;
					4'b0000: aluControl = aluAnd;
					4'b1100: aluControl = aluOrr;
					4'b0001: aluControl = aluEor;
					default: aluControl = aluAdd;
				endcase
			end
			// C and V only follow the adder
			flagW[1] = sBit;
			flagW[0] = sBit & ((aluControl == aluAdd) | (aluControl == aluSub));
		end
	end

	always_comb begin
		case (op)
			opMem:    immSrc = immMem;
			opBranch: immSrc = immBranch;
			default:  immSrc = immDp;
		endcase
	end

	// Bit 1 reads Rd for STR, bit 0 reads R15 for B
	assign regSrc = {op == opMem, op == opBranch};

	assign dest = regSrcMul ? instr[19:16] : instr[15:12];
	assign pcs  = isBranch | (regW & (dest == pcReg));

endmodule

// ==== logic/unifiedMem.sv ====
// Unified instruction and data memory, word addressed, loaded from the program file
`timescale 1ns/1ns

module unifiedMem (
	input  logic         clk,
	input  logic         we,
	input  armPkg::wordT a,
	input  armPkg::wordT wd,
	output armPkg::wordT rd
);
	import armPkg::*;

	wordT mem [memWords];
	logic [$clog2(memWords)-1:0] wordIdx;

	initial begin
		$readmemh("memfile.dat", mem);
	end

	// Byte address to word index, low two bits ignored
	assign wordIdx = a[$clog2(memWords)+1:2];

	assign rd = mem[wordIdx];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wordIdx] <= wd;
		end
	end

endmodule

// ==== logic/armTop.sv ====
// Top level: processor control, condition unit, datapath and unified memory
`timescale 1ns/1ns

module armTop (
	input  logic         clk,
	input  logic         reset,
	output armPkg::wordT writeData,
	output armPkg::wordT adr,
	output logic         memWrite
);
	import armPkg::*;

	wordT    readData;
	wordT    instr;
	flagsT   aluFlags;
	logic    irWrite;
	logic    adrSrc;
	logic    aluSrcA;
	logic    regW;
	logic    memW;
	logic    nextPc;
	logic    pcs;
	logic    regSrcMul;
	logic    pcWrite;
	logic    regWrite;
	logic    [1:0] aluSrcB;
	logic    [1:0] resultSrc;
	logic    [1:0] regSrc;
	logic    [1:0] flagW;
	immSrcT  immSrc;
	aluCtrlT aluControl;

	controlFsm u_controlFsm (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.irWrite    (irWrite),
		.adrSrc     (adrSrc),
		.aluSrcA    (aluSrcA),
		.regW       (regW),
		.memW       (memW),
		.nextPc     (nextPc),
		.pcs        (pcs),
		.regSrcMul  (regSrcMul),
		.aluSrcB    (aluSrcB),
		.resultSrc  (resultSrc),
		.immSrc     (immSrc),
		.regSrc     (regSrc),
		.aluControl (aluControl),
		.flagW      (flagW)
	);

	condUnit u_condUnit (
		.clk      (clk),
		.reset    (reset),
		.cond     (instr[31:28]),
		.aluFlags (aluFlags),
		.flagW    (flagW),
		.pcs      (pcs),
		.nextPc   (nextPc),
		.regW     (regW),
		.memW     (memW),
		.pcWrite  (pcWrite),
		.regWrite (regWrite),
		.memWrite (memWrite)
	);

	datapath u_datapath (
		.clk        (clk),
		.reset      (reset),
		.readData   (readData),
		.irWrite    (irWrite),
		.adrSrc     (adrSrc),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.resultSrc  (resultSrc),
		.immSrc     (immSrc),
		.regSrc     (regSrc),
		.regSrcMul  (regSrcMul),
		.aluControl (aluControl),
		.pcWrite    (pcWrite),
		.regWrite   (regWrite),
		.adr        (adr),
		.writeData  (writeData),
		.instr      (instr),
		.aluFlags   (aluFlags)
	);

	unifiedMem u_unifiedMem (
		.clk (clk),
		.we  (memWrite),
		.a   (adr),
		.wd  (writeData),
		.rd  (readData)
	);

endmodule

// ==== sim/armModel.svh ====
// Instruction-level reference model that predicts the stores of the test program
`ifndef ARM_MODEL_SVH
`define ARM_MODEL_SVH

// The program ends with a store here and then branches to itself
localparam logic [31:0] markerAdr = 32'h0000_00FC;

logic [31:0] modelMem [64];
logic [31:0] expAddr [$];
logic [31:0] expData [$];

// ARM condition codes, 15 never executes
function automatic bit condHolds(input logic [3:0] cond, input bit n, input bit z,
		input bit c, input bit v);
	case (cond)
		4'h0: return z;
		4'h1: return !z;
		4'h2: return c;
		4'h3: return !c;
		4'h4: return n;
		4'h5: return !n;
		4'h6: return v;
		4'h7: return !v;
		4'h8: return c && !z;
		4'h9: return !c || z;
		4'hA: return n == v;
		4'hB: return n != v;
		4'hC: return !z && (n == v);
		4'hD: return z || (n != v);
		4'hE: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// Runs the program and records every executed store in order
function automatic int predictStores();
	logic [31:0] regs [16];
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [31:0] memAdrV;
	logic [32:0] wide;
	logic [3:0] cmd;
	bit n;
	bit z;
	bit c;
	bit v;
	bit done;
	int steps;
	n = 0;
	z = 0;
	c = 0;
	v = 0;
	pc = '0;
	done = 0;
	steps = 0;
	for (int i = 0; i < 16; i++) begin
		regs[i] = '0;
	end
	$readmemh("memfile.dat", modelMem);
	while (!done && steps < 5000) begin
		instr = modelMem[pc[7:2]];
		// R15 reads see the instruction address plus 8
		regs[15] = pc + 32'd8;
		steps++;
		if (!condHolds(instr[31:28], n, z, c, v)) begin
			pc = pc + 32'd4;
		end else if (instr[27:26] == 2'b10) begin
			pc = pc + 32'd8 + {{6{instr[23]}}, instr[23:0], 2'b00};
		end else if (instr[27:26] == 2'b01) begin
			memAdrV = regs[instr[19:16]] + {20'd0, instr[11:0]};
			if (instr[20]) begin
				regs[instr[15:12]] = modelMem[memAdrV[7:2]];
			end else begin
				modelMem[memAdrV[7:2]] = regs[instr[15:12]];
				expAddr.push_back(memAdrV);
				expData.push_back(regs[instr[15:12]]);
				done = (memAdrV == markerAdr);
			end
			pc = pc + 32'd4;
		end else if (!instr[25] && instr[24:21] == 4'd0 && instr[7:4] == 4'd9) begin
			// MUL keeps the low word only
			res = regs[instr[3:0]] * regs[instr[11:8]];
			regs[instr[19:16]] = res;
			if (instr[20]) begin
				n = res[31];
				z = (res == 0);
			end
			pc = pc + 32'd4;
		end else begin
			cmd = instr[24:21];
			a = regs[instr[19:16]];
			b = instr[25] ? {24'd0, instr[7:0]} : regs[instr[3:0]];
			case (cmd)
				4'b0100: res = a + b;
				4'b0010: res = a - b;
				4'b0000: res = a & b;
				4'b1100: res = a | b;
				default: res = a ^ b;
			endcase
			if (instr[20]) begin
				n = res[31];
				z = (res == 0);
				if (cmd == 4'b0100) begin
					wide = {1'b0, a} + {1'b0, b};
					c = wide[32];
					v = (a[31] == b[31]) && (res[31] != a[31]);
				end else if (cmd == 4'b0010) begin
					c = (a >= b);
					v = (a[31] != b[31]) && (res[31] != a[31]);
				end
			end
			regs[instr[15:12]] = res;
			pc = (instr[15:12] == 4'd15) ? res : pc + 32'd4;
		end
	end
	return expAddr.size();
endfunction

`endif

// ==== sim/armTb.sv ====
// Clock, reset, DUT instance, store checks against the reference model and the final report
`timescale 1ns/1ns

module armTb;

	localparam int storeTimeout = 2000;

	logic        clk;
	logic        reset;
	logic [31:0] writeData;
	logic [31:0] adr;
	logic        memWrite;
	int          valErrors;
	int          otherErrors;
	int          expCount;
	int          seen;

	`include "armModel.svh"

	armTop u_armTop (
		.clk       (clk),
		.reset     (reset),
		.writeData (writeData),
		.adr       (adr),
		.memWrite  (memWrite)
	);

	always #2 clk = ~clk;

	// Waits for the next store pulse on a falling edge
	task automatic waitStore(output bit got);
		int cycles;
		got = 0;
		cycles = 0;
		while (!got && cycles < storeTimeout) begin
			@(negedge clk);
			if (memWrite) begin
				got = 1;
			end else begin
				cycles++;
			end
		end
	endtask

	task automatic checkIdle(input string name);
		assert (memWrite == 1'b0) else begin
			$display("Error %s memWrite: expected 0, actual %b", name, memWrite);
			valErrors++;
		end
		assert (adr == 32'd0) else begin
			$display("Error %s adr: expected %h, actual %h", name, 32'd0, adr);
			valErrors++;
		end
	endtask

	initial begin
		bit got;
		bit marker;
		clk = 1'b0;
		reset = 1'b1;
		valErrors = 0;
		otherErrors = 0;
		seen = 0;
		expCount = predictStores();

		repeat (16) begin
			@(negedge clk);
			checkIdle("reset");
		end
		reset = 1'b0;
		#1;
		checkIdle("after reset");

		marker = 0;
		got = 1;
		// Ends at the marker store, on a timeout or after one store too many
		while (!marker && got && seen <= expCount) begin
			waitStore(got);
			if (!got) begin
				$display("Timeout: no store arrived within %0d cycles", storeTimeout);
				otherErrors++;
			end else begin
				assert (seen < expCount) else begin
					$display("Unexpected extra store to %h with data %h", adr, writeData);
					otherErrors++;
				end
				if (seen < expCount) begin
					assert (adr == expAddr[seen]) else begin
						$display("Error store %0d address: expected %h, actual %h",
							seen, expAddr[seen], adr);
						valErrors++;
					end
					assert (writeData == expData[seen]) else begin
						$display("Error store %0d data: expected %h, actual %h",
							seen, expData[seen], writeData);
						valErrors++;
					end
				end
				marker = (adr == markerAdr);
				seen++;
			end
		end

		assert (seen == expCount) else begin
			$display("Store count differs from the model: expected %0d, saw %0d",
				expCount, seen);
			otherErrors++;
		end

		$display("Errors: %0d wrong values, %0d other failures", valErrors, otherErrors);
		if (valErrors + otherErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== memfile.dat ====
// One instruction word per line in hex, word 0 at address 0
// Data area starts at 0xC0, marker store goes to 0xFC
E04F000F // SUB R0, PC, PC
E28010C0 // ADD R1, R0, #0xC0
E2802007 // ADD R2, R0, #7
E280300C // ADD R3, R0, #12
E0824003 // ADD R4, R2, R3
E5814000 // STR R4, [R1]
E0434002 // SUB R4, R3, R2
E5814004 // STR R4, [R1, #4]
E0034002 // AND R4, R3, R2
E1835002 // ORR R5, R3, R2
E0246005 // EOR R6, R4, R5
E5816008 // STR R6, [R1, #8]
E22270FF // EOR R7, R2, #0xFF
E3877005 // ORR R7, R7, #5
E207703C // AND R7, R7, #0x3C
E247700C // SUB R7, R7, #12
E581700C // STR R7, [R1, #12]
E0080392 // MUL R8, R2, R3
E5818010 // STR R8, [R1, #16]
E5919010 // LDR R9, [R1, #16]
E5819014 // STR R9, [R1, #20]
E052A003 // SUBS R10, R2, R3
45812018 // STRMI R2, [R1, #24]
A5813018 // STRGE R3, [R1, #24]
B581A018 // STRLT R10, [R1, #24]
2581301C // STRCS R3, [R1, #28]
E00B0191 // MUL R11, R1, R1
E00B0B9B // MUL R11, R11, R11
E09BC00B // ADDS R12, R11, R11
A581C01C // STRGE R12, [R1, #28]
B581201C // STRLT R2, [R1, #28]
E09CC00C // ADDS R12, R12, R12
8581C020 // STRHI R12, [R1, #32]
2581B020 // STRCS R11, [R1, #32]
E012D003 // ANDS R13, R2, R3
B5812024 // STRLT R2, [R1, #36]
E052D002 // SUBS R13, R2, R2
0581D028 // STREQ R13, [R1, #40]
15812028 // STRNE R2, [R1, #40]
85812028 // STRHI R2, [R1, #40]
EA000000 // B over the next store
E5812028 // STR R2, [R1, #40]
E2804003 // ADD R4, R0, #3
E2544001 // SUBS R4, R4, #1
E581402C // STR R4, [R1, #44]
1AFFFFFC // BNE back to SUBS
E581703C // STR R7, [R1, #60]
EAFFFFFE // B to itself

// ==== src.f ====
+incdir+sim
logic/armPkg.sv
logic/alu.sv
logic/regFile.sv
logic/datapath.sv
logic/condUnit.sv
logic/controlFsm.sv
logic/unifiedMem.sv
logic/armTop.sv
sim/armTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module armTb -f src.f -o armSim \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/armSim > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
